/* Makefile */
SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_alu_stage: src.f $(SRCS)
	verilator --binary --timing -Wno-fatal -j 0 --top-module tb_alu_stage -f src.f

run: obj_dir/Vtb_alu_stage
	./obj_dir/Vtb_alu_stage | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* rtl/alu_branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_branch_unit
(
    input  wire alu_pkg::alu_req_t         req,
    output logic                           taken,
    output logic [alu_pkg::pc_width-1:0]   target
);

    // Unsigned compares of ra against rb
    always_comb
    begin
        case (req.opcode)
            alu_pkg::OP_BEQ:  taken = (req.ra_data == req.rb_data);
            alu_pkg::OP_BNE:  taken = (req.ra_data != req.rb_data);
            alu_pkg::OP_BLT:  taken = (req.ra_data <  req.rb_data);
            alu_pkg::OP_BGT:  taken = (req.ra_data >  req.rb_data);
            alu_pkg::OP_BLE:  taken = (req.ra_data <= req.rb_data);
            alu_pkg::OP_BGE:  taken = (req.ra_data >= req.rb_data);
            alu_pkg::OP_JUMP: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // Absolute target taken from the offset field
    assign target = {{(alu_pkg::pc_width-alu_pkg::offset_width){1'b0}}, req.offset};

endmodule

`default_nettype wire

/* rtl/alu_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_exec
(
    input  wire alu_pkg::alu_req_t           req,
    output logic [alu_pkg::data_width-1:0]   rf_data,
    output logic                             overflow
);

    // Double width keeps the carry and shifted-out bits visible
    logic [2*alu_pkg::data_width-1:0] wide_ra;
    logic [2*alu_pkg::data_width-1:0] wide_rb;
    logic [2*alu_pkg::data_width-1:0] wide_offset;
    logic [2*alu_pkg::data_width-1:0] wide_result;
    logic                             check_upper;
    logic                             shift_past_width;

    assign wide_ra     = {{alu_pkg::data_width{1'b0}}, req.ra_data};
    assign wide_rb     = {{alu_pkg::data_width{1'b0}}, req.rb_data};
    assign wide_offset = {{(2*alu_pkg::data_width-alu_pkg::offset_width){1'b0}}, req.offset};

    assign shift_past_width = (wide_offset >= alu_pkg::data_width);

    always_comb
    begin
        wide_result = '0;
        check_upper = 1'b0;
        case (req.opcode)
            alu_pkg::OP_ADD:
            begin
                wide_result = wide_ra + wide_rb;
                check_upper = 1'b1;
            end
            alu_pkg::OP_SUB:
            begin
                wide_result = wide_ra - wide_rb;
            end
            alu_pkg::OP_ADDI:
            begin
                wide_result = wide_ra + wide_offset;
                check_upper = 1'b1;
            end
            alu_pkg::OP_SLL:
            begin
                wide_result = wide_ra << req.offset;
                check_upper = 1'b1;
            end
            alu_pkg::OP_SRL:
            begin
                wide_result = wide_ra >> req.offset;
            end
            alu_pkg::OP_MOV:
            begin
                wide_result = wide_ra;
            end
            default:
            begin
                wide_result = '0;
            end
        endcase
    end

    assign rf_data = wide_result[alu_pkg::data_width-1:0];

    always_comb
    begin
        overflow = 1'b0;
        if (check_upper)
        begin
            // Shifting by a full word or more drops every set bit of ra
            if ((req.opcode == alu_pkg::OP_SLL) && shift_past_width)
                overflow = (req.ra_data != '0);
            else
                overflow = (wide_result[2*alu_pkg::data_width-1:alu_pkg::data_width] != '0);
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_mem_agen.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_mem_agen
(
    input  wire alu_pkg::alu_req_t           req,
    output logic [alu_pkg::data_width-1:0]   addr,
    output logic [alu_pkg::data_width-1:0]   store_data,
    output logic                             is_store,
    output alu_pkg::mem_size_e               size,
    output logic                             overflow
);

    logic                           is_load;
    logic                           is_byte;
    logic [alu_pkg::data_width-1:0] base;
    logic [alu_pkg::data_width:0]   sum;

    assign is_load  = (req.opcode == alu_pkg::OP_LDW) || (req.opcode == alu_pkg::OP_LDB);
    assign is_store = (req.opcode == alu_pkg::OP_STW) || (req.opcode == alu_pkg::OP_STB);
    assign is_byte  = (req.opcode == alu_pkg::OP_LDB) || (req.opcode == alu_pkg::OP_STB);

    // Loads address through ra, stores through rb since ra holds the data
    assign base = is_load ? req.ra_data : req.rb_data;

    // One extra bit catches the address carry
    assign sum = {1'b0, base}
               + {{(alu_pkg::data_width+1-alu_pkg::offset_width){1'b0}}, req.offset};

    assign addr       = sum[alu_pkg::data_width-1:0];
    assign overflow   = sum[alu_pkg::data_width];
    assign store_data = req.ra_data;
    assign size       = is_byte ? alu_pkg::SIZE_BYTE : alu_pkg::SIZE_WORD;

endmodule

`default_nettype wire

/* rtl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    ////////////////////////////////////////
    // Widths
    localparam int data_width     = 32;
    localparam int offset_width   = 16;
    localparam int pc_width       = 32;
    localparam int rob_id_width   = 6;
    localparam int reg_addr_width = 5;

    ////////////////////////////////////////
    // Encodings
    typedef enum logic [4:0]
    {
        OP_ADD  = 5'h00,
        OP_SUB  = 5'h01,
        OP_ADDI = 5'h02,
        OP_SLL  = 5'h03,
        OP_SRL  = 5'h04,
        OP_MOV  = 5'h05,
        OP_LDW  = 5'h08,
        OP_LDB  = 5'h09,
        OP_STW  = 5'h0a,
        OP_STB  = 5'h0b,
        OP_BEQ  = 5'h10,
        OP_BNE  = 5'h11,
        OP_BLT  = 5'h12,
        OP_BGT  = 5'h13,
        OP_BLE  = 5'h14,
        OP_BGE  = 5'h15,
        OP_JUMP = 5'h16
    } alu_opcode_e;

    typedef enum logic
    {
        SIZE_WORD = 1'b0,
        SIZE_BYTE = 1'b1
    } mem_size_e;

    ////////////////////////////////////////
    // Requests
    typedef struct packed
    {
        alu_opcode_e                opcode;
        logic [data_width-1:0]      ra_data;
        logic [data_width-1:0]      rb_data;
        logic [offset_width-1:0]    offset;
        logic [reg_addr_width-1:0]  rd_addr;
        logic [rob_id_width-1:0]    instr_id;
        logic [pc_width-1:0]        pc;
    } alu_req_t;

    typedef struct packed
    {
        logic [rob_id_width-1:0]    instr_id;
        logic [pc_width-1:0]        pc;
        logic                       rf_wen;
        logic [reg_addr_width-1:0]  rf_dest;
        logic [data_width-1:0]      rf_data;
        logic                       xcpt_overflow;
        logic                       mem_blocked;
    } wb_req_t;

    typedef struct packed
    {
        logic [rob_id_width-1:0]    instr_id;
        logic [pc_width-1:0]        pc;
        logic [reg_addr_width-1:0]  rd_addr;
        logic [data_width-1:0]      addr;
        logic [data_width-1:0]      data;
        logic                       is_store;
        mem_size_e                  size;
    } dcache_req_t;

endpackage

`default_nettype wire

/* rtl/alu_route_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_route_ctrl
(
    input  wire logic                              clock,
    input  wire logic                              arst_n,
    input  wire logic                              req_valid,
    input  wire logic                              flush,
    input  wire logic                              dcache_ready,
    input  wire logic [alu_pkg::rob_id_width-1:0]  rob_tail,
    input  wire alu_pkg::alu_req_t                 req,

    // Datapath results
    input  wire logic [alu_pkg::data_width-1:0]    exec_data,
    input  wire logic                              exec_overflow,
    input  wire logic                              br_taken,
    input  wire logic [alu_pkg::pc_width-1:0]      br_target,
    input  wire logic [alu_pkg::data_width-1:0]    agen_addr,
    input  wire logic [alu_pkg::data_width-1:0]    agen_data,
    input  wire logic                              agen_is_store,
    input  wire alu_pkg::mem_size_e                agen_size,
    input  wire logic                              agen_overflow,

    output logic                                   wb_valid,
    output alu_pkg::wb_req_t                       wb,
    output logic                                   dcache_valid,
    output alu_pkg::dcache_req_t                   dcache,
    output logic                                   take_branch,
    output logic [alu_pkg::pc_width-1:0]           branch_pc
);

    logic                 accept;
    logic                 is_arith;
    logic                 is_move;
    logic                 is_mem;
    logic                 is_branch;
    logic                 xcpt;
    logic                 mem_granted;
    alu_pkg::wb_req_t     wb_next;
    alu_pkg::dcache_req_t dcache_next;

    ////////////////////////////////////////
    // Opcode classes
    always_comb
    begin
        is_arith  = 1'b0;
        is_move   = 1'b0;
        is_mem    = 1'b0;
        is_branch = 1'b0;
        case (req.opcode)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_ADDI,
            alu_pkg::OP_SLL, alu_pkg::OP_SRL:
                is_arith = 1'b1;
            alu_pkg::OP_MOV:
                is_move = 1'b1;
            alu_pkg::OP_LDW, alu_pkg::OP_LDB, alu_pkg::OP_STW, alu_pkg::OP_STB:
                is_mem = 1'b1;
            alu_pkg::OP_BEQ, alu_pkg::OP_BNE, alu_pkg::OP_BLT, alu_pkg::OP_BGT,
            alu_pkg::OP_BLE, alu_pkg::OP_BGE, alu_pkg::OP_JUMP:
                is_branch = 1'b1;
            default:
                is_branch = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Routing decision
    assign accept = req_valid && !flush;

    // Overflow only counts from the unit that serves this opcode
    assign xcpt = (is_arith && exec_overflow) || (is_mem && agen_overflow);

    // Cache access only for the oldest op in the RoB
    assign mem_granted = is_mem && !xcpt && dcache_ready && (rob_tail == req.instr_id);

    always_comb
    begin
        wb_next.instr_id      = req.instr_id;
        wb_next.pc            = req.pc;
        wb_next.rf_wen        = (is_arith || is_move) && !xcpt;
        wb_next.rf_dest       = req.rd_addr;
        wb_next.rf_data       = is_branch ? '0 : exec_data;
        wb_next.xcpt_overflow = xcpt;
        wb_next.mem_blocked   = is_mem && !xcpt && !mem_granted;

        dcache_next.instr_id  = req.instr_id;
        dcache_next.pc        = req.pc;
        dcache_next.rd_addr   = req.rd_addr;
        dcache_next.addr      = agen_addr;
        dcache_next.data      = agen_data;
        dcache_next.is_store  = agen_is_store;
        dcache_next.size      = agen_size;
    end

    ////////////////////////////////////////
    // Output registers
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_valid     <= 1'b0;
            dcache_valid <= 1'b0;
            take_branch  <= 1'b0;
        end
        else
        begin
            wb_valid     <= accept && !mem_granted;
            dcache_valid <= accept && mem_granted;
            take_branch  <= accept && is_branch && br_taken;
        end
    end

    // Payloads only follow accepted requests
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            wb        <= wb_next;
            dcache    <= dcache_next;
            branch_pc <= br_target;
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_stage
(
    input  wire logic                              clock,
    input  wire logic                              arst_n,

    // Request from decode
    input  wire logic                              req_valid,
    input  wire alu_pkg::alu_req_t                 req,

    // Sampled levels
    input  wire logic                              flush,
    input  wire logic                              dcache_ready,
    input  wire logic [alu_pkg::rob_id_width-1:0]  rob_tail,

    // To write-back
    output logic                                   wb_valid,
    output alu_pkg::wb_req_t                       wb,

    // To data cache
    output logic                                   dcache_valid,
    output alu_pkg::dcache_req_t                   dcache,

    // To fetch
    output logic                                   take_branch,
    output logic [alu_pkg::pc_width-1:0]           branch_pc
);

    logic [alu_pkg::data_width-1:0] exec_data;
    logic                           exec_overflow;
    logic                           br_taken;
    logic [alu_pkg::pc_width-1:0]   br_target;
    logic [alu_pkg::data_width-1:0] agen_addr;
    logic [alu_pkg::data_width-1:0] agen_data;
    logic                           agen_is_store;
    alu_pkg::mem_size_e             agen_size;
    logic                           agen_overflow;

    ////////////////////////////////////////
    // Datapath
    alu_exec alu_exec_inst
    (
        .req      (req),
        .rf_data  (exec_data),
        .overflow (exec_overflow)
    );

    alu_branch_unit alu_branch_unit_inst
    (
        .req    (req),
        .taken  (br_taken),
        .target (br_target)
    );

    alu_mem_agen alu_mem_agen_inst
    (
        .req        (req),
        .addr       (agen_addr),
        .store_data (agen_data),
        .is_store   (agen_is_store),
        .size       (agen_size),
        .overflow   (agen_overflow)
    );

    ////////////////////////////////////////
    // Control and output registers
    alu_route_ctrl alu_route_ctrl_inst
    (
        .clock         (clock),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .flush         (flush),
        .dcache_ready  (dcache_ready),
        .rob_tail      (rob_tail),
        .req           (req),
        .exec_data     (exec_data),
        .exec_overflow (exec_overflow),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .agen_addr     (agen_addr),
        .agen_data     (agen_data),
        .agen_is_store (agen_is_store),
        .agen_size     (agen_size),
        .agen_overflow (agen_overflow),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .dcache_valid  (dcache_valid),
        .dcache        (dcache),
        .take_branch   (take_branch),
        .branch_pc     (branch_pc)
    );

endmodule

`default_nettype wire

/* src.f */
rtl/alu_pkg.sv
rtl/alu_exec.sv
rtl/alu_branch_unit.sv
rtl/alu_mem_agen.sv
rtl/alu_route_ctrl.sv
rtl/alu_stage.sv
test/alu_checker.sv
test/tb_alu_stage.sv

/* test/alu_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_checker
(
    input  wire logic                              clock,
    input  wire logic                              arst_n,
    input  wire logic                              req_valid,
    input  wire alu_pkg::alu_req_t                 req,
    input  wire logic                              flush,
    input  wire logic                              dcache_ready,
    input  wire logic [alu_pkg::rob_id_width-1:0]  rob_tail,
    input  wire logic                              wb_valid,
    input  wire alu_pkg::wb_req_t                  wb,
    input  wire logic                              dcache_valid,
    input  wire alu_pkg::dcache_req_t              dcache,
    input  wire logic                              take_branch,
    input  wire logic [alu_pkg::pc_width-1:0]      branch_pc,
    output int                                     error_count,
    output int                                     check_count
);

    logic                           exp_wb_valid = 1'b0;
    logic                           exp_dcache_valid = 1'b0;
    logic                           exp_take_branch = 1'b0;
    alu_pkg::wb_req_t               exp_wb;
    alu_pkg::dcache_req_t           exp_dcache;
    logic [alu_pkg::pc_width-1:0]   exp_branch_pc;

    initial
    begin
        error_count = 0;
        check_count = 0;
    end

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // Reference model of one request
    task automatic predict();
        logic [63:0] ra64;
        logic [63:0] rb64;
        logic [63:0] wide;
        logic [32:0] addr_sum;
        logic        ovf;
        logic        taken;
        logic        is_mem;
        logic        is_store;
        logic        is_branch;
        logic        writes_rf;
        logic        granted;
        logic        accept;
        ra64 = {32'd0, req.ra_data};
        rb64 = {32'd0, req.rb_data};
        ovf  = 1'b0;
        is_mem    = req.opcode inside {alu_pkg::OP_LDW, alu_pkg::OP_LDB,
                                       alu_pkg::OP_STW, alu_pkg::OP_STB};
        is_store  = req.opcode inside {alu_pkg::OP_STW, alu_pkg::OP_STB};
        writes_rf = req.opcode inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_ADDI,
                                       alu_pkg::OP_SLL, alu_pkg::OP_SRL, alu_pkg::OP_MOV};
        is_branch = !is_mem && !writes_rf;

        case (req.opcode)
            alu_pkg::OP_ADD:  wide = ra64 + rb64;
            alu_pkg::OP_SUB:  wide = ra64 - rb64;
            alu_pkg::OP_ADDI: wide = ra64 + {48'd0, req.offset};
            alu_pkg::OP_SLL:  wide = (req.offset >= 16'd32) ? 64'd0 : ra64 << req.offset;
            alu_pkg::OP_SRL:  wide = ra64 >> req.offset;
            alu_pkg::OP_MOV:  wide = ra64;
            default:          wide = 64'd0;
        endcase
        if (req.opcode inside {alu_pkg::OP_ADD, alu_pkg::OP_ADDI})
            ovf = (wide[63:32] != 32'd0);
        // Any set bit of ra is lost once the shift reaches a full word
        if (req.opcode == alu_pkg::OP_SLL)
            ovf = (req.offset >= 16'd32) ? (req.ra_data != '0) : (wide[63:32] != 32'd0);

        case (req.opcode)
            alu_pkg::OP_BEQ:  taken = (req.ra_data == req.rb_data);
            alu_pkg::OP_BNE:  taken = (req.ra_data != req.rb_data);
            alu_pkg::OP_BLT:  taken = (req.ra_data < req.rb_data);
            alu_pkg::OP_BGT:  taken = (req.ra_data > req.rb_data);
            alu_pkg::OP_BLE:  taken = (req.ra_data <= req.rb_data);
            alu_pkg::OP_BGE:  taken = (req.ra_data >= req.rb_data);
            alu_pkg::OP_JUMP: taken = 1'b1;
            default:          taken = 1'b0;
        endcase

        // Stores take their base from rb
        addr_sum = (is_store ? {1'b0, req.rb_data} : {1'b0, req.ra_data}) + {17'd0, req.offset};
        if (is_mem)
            ovf = addr_sum[32];

        granted = is_mem && !ovf && dcache_ready && (rob_tail == req.instr_id);
        accept  = arst_n && req_valid && !flush;

        exp_wb_valid     = accept && !granted;
        exp_dcache_valid = accept && granted;
        exp_take_branch  = accept && is_branch && taken;

        exp_wb.instr_id      = req.instr_id;
        exp_wb.pc            = req.pc;
        exp_wb.rf_wen        = writes_rf && !ovf;
        exp_wb.rf_dest       = req.rd_addr;
        exp_wb.rf_data       = wide[31:0];
        exp_wb.xcpt_overflow = ovf;
        exp_wb.mem_blocked   = is_mem && !ovf && !granted;

        exp_dcache.instr_id  = req.instr_id;
        exp_dcache.pc        = req.pc;
        exp_dcache.rd_addr   = req.rd_addr;
        exp_dcache.addr      = addr_sum[31:0];
        exp_dcache.data      = req.ra_data;
        exp_dcache.is_store  = is_store;
        exp_dcache.size      = req.opcode inside {alu_pkg::OP_LDB, alu_pkg::OP_STB}
                             ? alu_pkg::SIZE_BYTE : alu_pkg::SIZE_WORD;

        exp_branch_pc = {16'd0, req.offset};
    endtask

    task automatic compare_outputs();
        check_value(128'(wb_valid), 128'(exp_wb_valid), "wb_valid");
        check_value(128'(dcache_valid), 128'(exp_dcache_valid), "dcache_valid");
        check_value(128'(take_branch), 128'(exp_take_branch), "take_branch");
        if (exp_wb_valid && wb_valid)
            check_value(128'(wb), 128'(exp_wb),
                        $sformatf("wb payload of id %0d", exp_wb.instr_id));
        if (exp_dcache_valid && dcache_valid)
            check_value(128'(dcache), 128'(exp_dcache),
                        $sformatf("dcache payload of id %0d", exp_dcache.instr_id));
        if (exp_take_branch && take_branch)
            check_value(128'(branch_pc), 128'(exp_branch_pc), "branch_pc");
    endtask

    // Outputs of the last edge first, then the request for the next edge
    always @(negedge clock)
    begin
        compare_outputs();
        predict();
    end

endmodule

`default_nettype wire

/* test/tb_alu_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_alu_stage;

    localparam int num_tests       = 6;
    localparam int cycles_per_test = 200;
    localparam int cycle_limit     = num_tests * cycles_per_test + 100;

    logic                              clock;
    logic                              arst_n;
    logic                              req_valid;
    alu_pkg::alu_req_t                 req;
    logic                              flush;
    logic                              dcache_ready;
    logic [alu_pkg::rob_id_width-1:0]  rob_tail;
    logic                              wb_valid;
    alu_pkg::wb_req_t                  wb;
    logic                              dcache_valid;
    alu_pkg::dcache_req_t              dcache;
    logic                              take_branch;
    logic [alu_pkg::pc_width-1:0]      branch_pc;

    int                                error_count;
    int                                check_count;
    int                                cycle_count;
    logic [31:0]                       rnd_state;
    alu_pkg::alu_opcode_e              op_table [17];

    alu_stage alu_stage_inst
    (
        .clock        (clock),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .flush        (flush),
        .dcache_ready (dcache_ready),
        .rob_tail     (rob_tail),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .dcache_valid (dcache_valid),
        .dcache       (dcache),
        .take_branch  (take_branch),
        .branch_pc    (branch_pc)
    );

    alu_checker alu_checker_inst
    (
        .clock        (clock),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .flush        (flush),
        .dcache_ready (dcache_ready),
        .rob_tail     (rob_tail),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .dcache_valid (dcache_valid),
        .dcache       (dcache),
        .take_branch  (take_branch),
        .branch_pc    (branch_pc),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////
    // Random helpers
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic advance_rand(output logic [31:0] r);
        rnd_state = xorshift(rnd_state);
        r = rnd_state;
    endtask

    // Small, all-ones and near all-ones values hit carries and compare edges
    function automatic logic [31:0] shape_operand(input logic [31:0] r, input logic bias_high);
        if (bias_high && (r[1:0] != 2'd0))
            return ~{28'd0, r[5:2]};
        case (r[1:0])
            2'd0:    return r;
            2'd1:    return {30'd0, r[3:2]};
            2'd2:    return '1;
            default: return r >> r[6:2];
        endcase
    endfunction

    function automatic alu_pkg::alu_opcode_e pick_opcode(input int group, input logic [31:0] r);
        int idx;
        case (group)
            0: idx = r % 6;
            1:
            begin
                case (r % 5)
                    0:       idx = 0;
                    1:       idx = 2;
                    2:       idx = 3;
                    3:       idx = 6;
                    default: idx = 8;
                endcase
            end
            2: idx = 10 + r % 7;
            3: idx = 6 + r % 4;
            default: idx = r % 17;
        endcase
        return op_table[idx];
    endfunction

    function automatic string test_name(input int group);
        case (group)
            0:       return "arith_move";
            1:       return "overflow";
            2:       return "branch";
            3:       return "memory";
            4:       return "flush_idle";
            default: return "back_to_back";
        endcase
    endfunction

    ////////////////////////////////////////
    // One request cycle
    task automatic drive_cycle(input int group);
        logic [31:0]       r;
        alu_pkg::alu_req_t next_req;
        logic              bias_high;
        @(posedge clock);
        #2;
        bias_high = (group == 1);
        advance_rand(r);
        next_req.opcode = pick_opcode(group, r);
        advance_rand(r);
        next_req.ra_data = shape_operand(r, bias_high);
        advance_rand(r);
        next_req.rb_data = (r[9:8] == 2'd0) ? next_req.ra_data : shape_operand(r, bias_high);
        advance_rand(r);
        case (r[1:0])
            2'd0:    next_req.offset = {10'd0, r[7:2]};
            2'd1:    next_req.offset = 16'hffff;
            default: next_req.offset = r[31:16];
        endcase
        advance_rand(r);
        next_req.rd_addr  = r[4:0];
        next_req.instr_id = r[10:5];
        advance_rand(r);
        next_req.pc = r;
        advance_rand(r);
        req          = next_req;
        rob_tail     = r[0] ? next_req.instr_id : r[6:1];
        dcache_ready = (r[3:2] != 2'd0);
        case (group)
            4:
            begin
                req_valid = r[8];
                flush     = (r[12:11] == 2'd0);
            end
            5:
            begin
                req_valid = 1'b1;
                flush     = 1'b0;
            end
            default:
            begin
                req_valid = (r[10:8] != 3'd0);
                flush     = (r[15:12] == 4'd0);
            end
        endcase
    endtask

    initial
    begin
        int errors_before;
        op_table = '{alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_ADDI, alu_pkg::OP_SLL,
                     alu_pkg::OP_SRL, alu_pkg::OP_MOV, alu_pkg::OP_LDW, alu_pkg::OP_LDB,
                     alu_pkg::OP_STW, alu_pkg::OP_STB, alu_pkg::OP_BEQ, alu_pkg::OP_BNE,
                     alu_pkg::OP_BLT, alu_pkg::OP_BGT, alu_pkg::OP_BLE, alu_pkg::OP_BGE,
                     alu_pkg::OP_JUMP};
        rnd_state    = 32'h087f9125;
        arst_n       = 1'b0;
        // Requests offered during reset must not reach the outputs
        req_valid    = 1'b1;
        req          = '0;
        flush        = 1'b0;
        dcache_ready = 1'b0;
        rob_tail     = '0;
        repeat (8) @(posedge clock);
        #2;
        arst_n    = 1'b1;
        req_valid = 1'b0;

        for (int t = 0; t < num_tests; t++)
        begin
            errors_before = error_count;
            repeat (cycles_per_test) drive_cycle(t);
            $display("Test %0d %s finished with %0d errors",
                     t, test_name(t), error_count - errors_before);
        end

        // Drain the last request
        @(posedge clock);
        #2;
        req_valid = 1'b0;
        flush     = 1'b0;
        repeat (2) @(negedge clock);

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 num_tests, check_count, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
